//--- Bender.yml
package:
  name: asic_video

export_include_dirs:
  - include

sources:
  - src/asic_pkg.sv
  - src/video_timing.sv
  - src/io_regs.sv
  - src/vram_fetch.sv
  - src/pixel_serializer.sv
  - src/clut_palette.sv
  - src/asic_top.sv
  - target: test
    files:
      - verif/asic_assertions.sv
      - verif/asic_tb.sv

//--- filelist.f
+incdir+include
src/asic_pkg.sv
src/video_timing.sv
src/io_regs.sv
src/vram_fetch.sv
src/pixel_serializer.sv
src/clut_palette.sv
src/asic_top.sv
verif/asic_assertions.sv
verif/asic_tb.sv

//--- include/asic_params.svh
`ifndef ASIC_PARAMS_SVH
`define ASIC_PARAMS_SVH

// Horizontal raster, in clocks
`define ASIC_HACTIVE       512
`define ASIC_RBORDER       64
`define ASIC_HFPORCH       16
`define ASIC_HSYNC         64
`define ASIC_HBPORCH       64
`define ASIC_LBORDER       48
`define ASIC_HTOTAL        (`ASIC_RBORDER + `ASIC_HFPORCH + `ASIC_HSYNC + \
                            `ASIC_HBPORCH + `ASIC_LBORDER + `ASIC_HACTIVE)

// Vertical raster, in lines
`define ASIC_VACTIVE       192
`define ASIC_BBORDER       48
`define ASIC_VFPORCH       4
`define ASIC_VSYNC         4
`define ASIC_VBPORCH       16
`define ASIC_TBORDER       48
`define ASIC_VTOTAL        (`ASIC_VACTIVE + `ASIC_BBORDER + `ASIC_VFPORCH + \
                            `ASIC_VSYNC + `ASIC_VBPORCH + `ASIC_TBORDER)

// First clock of the paper fetch in a line
`define ASIC_FETCH_HSTART  256

// CPU I/O ports, low address byte
`define ASIC_PORT_VMPR     8'd252
`define ASIC_PORT_BORDER   8'd254
`define ASIC_PORT_LINEINT  8'd249
`define ASIC_PORT_STATUS   8'd249
`define ASIC_PORT_CLUT     8'd248

// Shift register load slot within a 16-clock group
`define ASIC_SLOT_LOAD     9

`endif

//--- src/asic_pkg.sv
package asic_pkg;

    // CPU side of the bus as seen by the I/O decoder
    typedef struct packed {
        logic        iorq_n;
        logic        rd_n;
        logic        wr_n;
        logic [15:0] addr;
        logic [7:0]  data;
    } cpu_bus_t;

    // Raster position and the window flags decoded from it
    typedef struct packed {
        logic [9:0] hc;
        logic [8:0] vc;
        logic       fetching;
        logic       blank;
        logic       frame_end;
    } beam_t;

    // Control register fields used by the video path
    typedef struct packed {
        logic [1:0] screen_mode;
        logic [4:0] screen_page;
        logic [3:0] clut_border;
        logic       screen_off;
        logic [7:0] lineint;
    } video_cfg_t;

    // Four bytes captured in one 16-clock group
    typedef struct packed {
        logic [7:0] byte0;
        logic [7:0] byte1;
        logic [7:0] byte2;
        logic [7:0] byte3;
    } fetch_group_t;

    // GRB high bits, bright, GRB low bits
    typedef struct packed {
        logic g_hi;
        logic r_hi;
        logic b_hi;
        logic bright;
        logic g_lo;
        logic r_lo;
        logic b_lo;
    } colour_t;

    typedef struct packed {
        logic       en;
        logic [3:0] idx;
        colour_t    colour;
    } clut_wr_t;

endpackage

//--- src/asic_top.sv
`timescale 1ns/1ps

module asic_top (
    input  logic               clk,
    input  logic               rst_n,
    input  asic_pkg::cpu_bus_t bus,
    input  logic [7:0]         ram_data,
    output logic [18:0]        vram_addr,
    output logic [7:0]         data_to_cpu,
    output logic               data_enable_n,
    output logic               csync,
    output logic               int_n,
    output asic_pkg::colour_t  pixel
);

    asic_pkg::beam_t        beam;
    asic_pkg::video_cfg_t   cfg;
    asic_pkg::clut_wr_t     clut_wr;
    asic_pkg::fetch_group_t group;
    logic [3:0]             index;
    logic                   vint_n;
    logic                   rint_n;

    video_timing u_timing (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfg    (cfg),
        .beam   (beam),
        .csync  (csync),
        .int_n  (int_n),
        .vint_n (vint_n),
        .rint_n (rint_n)
    );

    io_regs u_io (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (bus),
        .vint_n        (vint_n),
        .rint_n        (rint_n),
        .cfg           (cfg),
        .clut_wr       (clut_wr),
        .data_to_cpu   (data_to_cpu),
        .data_enable_n (data_enable_n)
    );

    vram_fetch u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .beam      (beam),
        .cfg       (cfg),
        .ram_data  (ram_data),
        .vram_addr (vram_addr),
        .group     (group)
    );

    pixel_serializer u_serializer (
        .clk   (clk),
        .rst_n (rst_n),
        .beam  (beam),
        .cfg   (cfg),
        .group (group),
        .index (index)
    );

    clut_palette u_palette (
        .clk     (clk),
        .rst_n   (rst_n),
        .clut_wr (clut_wr),
        .index   (index),
        .blank   (beam.blank),
        .pixel   (pixel)
    );

endmodule

//--- src/clut_palette.sv
`timescale 1ns/1ps

module clut_palette (
    input  logic               clk,
    input  logic               rst_n,
    input  asic_pkg::clut_wr_t clut_wr,
    input  logic [3:0]         index,
    input  logic               blank,
    output asic_pkg::colour_t  pixel
);

    asic_pkg::colour_t clut [16];

    // Same GRB on both bit pairs, bright from the top index bit
    function automatic asic_pkg::colour_t default_colour(input logic [3:0] i);
        logic bright;
        bright = i[3] && (i[2:0] != 3'd0);
        return asic_pkg::colour_t'({i[2:0], bright, i[2:0]});
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++)
                clut[i] <= default_colour(4'(i));
        end else if (clut_wr.en) begin
            clut[clut_wr.idx] <= clut_wr.colour;
        end
    end

    assign pixel = blank ? '0 : clut[index];

endmodule

//--- src/io_regs.sv
`timescale 1ns/1ps
`include "asic_params.svh"

module io_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  asic_pkg::cpu_bus_t   bus,
    input  logic                 vint_n,
    input  logic                 rint_n,
    output asic_pkg::video_cfg_t cfg,
    output asic_pkg::clut_wr_t   clut_wr,
    output logic [7:0]           data_to_cpu,
    output logic                 data_enable_n
);

    logic [7:0] vmpr;
    logic [7:0] border;
    logic [7:0] lineint;
    logic [7:0] port;
    logic       io_wr;
    logic       io_rd;

    assign port  = bus.addr[7:0];
    assign io_wr = !bus.iorq_n && !bus.wr_n;
    assign io_rd = !bus.iorq_n && !bus.rd_n;

    ///////////////////////////////
    // Control register writes
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vmpr    <= 8'h00;
            border  <= 8'h00;
            lineint <= 8'hff;
        end else if (io_wr) begin
            case (port)
                `ASIC_PORT_VMPR:    vmpr    <= bus.data;
                `ASIC_PORT_BORDER:  border  <= bus.data;
                `ASIC_PORT_LINEINT: lineint <= bus.data;
                default: ;
            endcase
        end
    end

    // Palette entry chosen by the high address byte
    assign clut_wr.en     = io_wr && (port == `ASIC_PORT_CLUT);
    assign clut_wr.idx    = bus.addr[11:8];
    assign clut_wr.colour = asic_pkg::colour_t'(bus.data[6:0]);

    assign cfg.screen_mode = vmpr[6:5];
    assign cfg.screen_page = vmpr[4:0];
    assign cfg.clut_border = {border[5], border[2:0]};
    // Screen off only applies in mode 4
    assign cfg.screen_off  = border[7] && (vmpr[6:5] == 2'd3);
    assign cfg.lineint     = lineint;

    ///////////////////////////////
    // CPU reads
    ///////////////////////////////
    always_comb begin
        data_enable_n = 1'b1;
        data_to_cpu   = 8'hff;
        if (io_rd) begin
            if (port == `ASIC_PORT_VMPR) begin
                data_enable_n = 1'b0;
                data_to_cpu   = vmpr;
            end else if (port == `ASIC_PORT_STATUS) begin
                data_enable_n = 1'b0;
                data_to_cpu   = {4'hf, vint_n, 2'b11, rint_n};
            end
        end
    end

endmodule

//--- src/pixel_serializer.sv
`timescale 1ns/1ps
`include "asic_params.svh"

module pixel_serializer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  asic_pkg::beam_t        beam,
    input  asic_pkg::video_cfg_t   cfg,
    input  asic_pkg::fetch_group_t group,
    output logic [3:0]             index
);

    logic [31:0] sreg4;
    logic [7:0]  sreg1;
    logic [7:0]  attr;
    logic        load;

    assign load = (beam.hc[3:0] == 4'(`ASIC_SLOT_LOAD));

    ///////////////////////////////
    // Shift registers
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sreg4 <= '0;
            sreg1 <= '0;
            attr  <= '0;
        end else if (load) begin
            if (beam.fetching) begin
                sreg4 <= group;
                sreg1 <= group.byte0;
                attr  <= group.byte2;
            end else begin
                // Border, so every pixel lands on the border entry
                sreg4 <= {8{cfg.clut_border}};
                sreg1 <= 8'h00;
                attr  <= {1'b0, cfg.clut_border, 3'b000};
            end
        end else if (beam.hc[0]) begin
            sreg4 <= {sreg4[27:0], 4'h0};
            sreg1 <= {sreg1[6:0], 1'b0};
        end
    end

    ///////////////////////////////
    // Index select
    ///////////////////////////////
    always_comb begin
        if (cfg.screen_mode == 2'd3)
            index = sreg4[31:28];
        else if (sreg1[7])
            index = {attr[6], attr[2:0]};   // ink
        else
            index = {attr[6], attr[5:3]};   // paper
    end

endmodule

//--- src/video_timing.sv
`timescale 1ns/1ps
`include "asic_params.svh"

module video_timing (
    input  logic                 clk,
    input  logic                 rst_n,
    input  asic_pkg::video_cfg_t cfg,
    output asic_pkg::beam_t      beam,
    output logic                 csync,
    output logic                 int_n,
    output logic                 vint_n,
    output logic                 rint_n
);

    localparam int HSYNC_START  = `ASIC_RBORDER + `ASIC_HFPORCH;
    localparam int HSYNC_END    = HSYNC_START + `ASIC_HSYNC;
    localparam int HBLANK_END   = HSYNC_END + `ASIC_HBPORCH;
    localparam int VBLANK_START = `ASIC_VACTIVE + `ASIC_BBORDER;
    localparam int VSYNC_START  = VBLANK_START + `ASIC_VFPORCH;
    localparam int VSYNC_END    = VSYNC_START + `ASIC_VSYNC;
    localparam int VBLANK_END   = VSYNC_END + `ASIC_VBPORCH;

    logic [9:0] hc;
    logic [8:0] vc;
    logic       line_end;
    logic       last_line;
    logic       in_hsync;
    logic       in_vsync;

    assign line_end  = (hc == 10'(`ASIC_HTOTAL - 1));
    assign last_line = (vc == 9'(`ASIC_VTOTAL - 1));

    ///////////////////////////////
    // Raster counters
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hc <= '0;
            vc <= '0;
        end else if (line_end) begin
            hc <= '0;
            vc <= last_line ? '0 : vc + 9'd1;
        end else begin
            hc <= hc + 10'd1;
        end
    end

    ///////////////////////////////
    // Sync and interrupts
    ///////////////////////////////
    assign in_hsync = (hc >= HSYNC_START) && (hc < HSYNC_END);
    assign in_vsync = (vc >= VSYNC_START) && (vc < VSYNC_END);

    // Equalising by inverting the line sync during vsync lines
    assign csync = ~in_hsync ^ in_vsync;

    assign vint_n = ~((vc == VSYNC_START) && (hc < `ASIC_FETCH_HSTART));
    // Line interrupt only fires for lines inside the paper area
    assign rint_n = ~((cfg.lineint <= 8'(`ASIC_VACTIVE - 1)) &&
                      (vc == {1'b0, cfg.lineint}) &&
                      (hc < `ASIC_FETCH_HSTART));
    assign int_n  = vint_n & rint_n;

    assign beam.hc        = hc;
    assign beam.vc        = vc;
    assign beam.fetching  = (vc < `ASIC_VACTIVE) && (hc >= `ASIC_FETCH_HSTART) &&
                            !cfg.screen_off;
    assign beam.blank     = ((hc >= `ASIC_RBORDER) && (hc < HBLANK_END)) ||
                            ((vc >= VBLANK_START) && (vc < VBLANK_END)) ||
                            cfg.screen_off;
    assign beam.frame_end = line_end && last_line;

endmodule

//--- src/vram_fetch.sv
`timescale 1ns/1ps

module vram_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  asic_pkg::beam_t        beam,
    input  asic_pkg::video_cfg_t   cfg,
    input  logic [7:0]             ram_data,
    output logic [18:0]            vram_addr,
    output asic_pkg::fetch_group_t group
);

    logic [14:0] offs;
    logic [4:0]  column;
    logic        mode4;
    logic        fetch_slot;

    assign mode4 = (cfg.screen_mode == 2'd3);
    // Odd clocks 1 to 7 of each group while the paper is fetched
    assign fetch_slot = beam.fetching && !beam.hc[3] && beam.hc[0];

    ///////////////////////////////
    // Address generation
    ///////////////////////////////
    always_comb begin
        if (mode4) begin
            vram_addr = {cfg.screen_page[4:1], offs};
        end else if (!beam.hc[2]) begin
            // Bitmap byte, interleaved line order
            vram_addr = {cfg.screen_page, 1'b0, beam.vc[7:6], beam.vc[2:0],
                         beam.vc[5:3], column};
        end else begin
            // Attribute byte for the 8-line cell row
            vram_addr = {cfg.screen_page, 4'b0110, beam.vc[7:3], column};
        end
    end

    ///////////////////////////////
    // Offset and column counters
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n || beam.frame_end) begin
            offs   <= '0;
            column <= '0;
        end else if (fetch_slot) begin
            if (mode4)
                offs <= offs + 15'd1;
            if (beam.hc[2:1] == 2'd3)
                column <= column + 5'd1;
        end
    end

    // Capture one byte per fetch slot
    always_ff @(posedge clk) begin
        if (fetch_slot) begin
            case (beam.hc[2:1])
                2'd0: group.byte0 <= ram_data;
                2'd1: group.byte1 <= ram_data;
                2'd2: group.byte2 <= ram_data;
                default: group.byte3 <= ram_data;
            endcase
        end
    end

endmodule

//--- verif/asic_assertions.sv
`timescale 1ns/1ps

module asic_assertions (
    input logic               clk,
    input logic               rst_n,
    input asic_pkg::cpu_bus_t bus,
    input logic               data_enable_n,
    input logic               csync,
    input logic               int_n
);

    int error_count = 0;

    // Read data only while an I/O cycle is active
    a_idle_bus: assert property (@(posedge clk) disable iff (!rst_n)
        bus.iorq_n |-> data_enable_n)
        else begin
            error_count++;
            $error("data_enable_n low while iorq_n is high");
        end

    // One interrupt source lasts 256 clocks at most
    a_int_width: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(int_n) |-> ##[1:256] int_n)
        else begin
            error_count++;
            $error("int_n held low for more than 256 clocks");
        end

    a_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({csync, int_n}))
        else begin
            error_count++;
            $error("csync or int_n unknown after reset");
        end

endmodule

bind asic_top asic_assertions assertions_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .bus           (bus),
    .data_enable_n (data_enable_n),
    .csync         (csync),
    .int_n         (int_n)
);

//--- verif/asic_tb.sv
`timescale 1ns/1ps
`include "asic_params.svh"

module asic_tb;

    localparam int HTOTAL       = `ASIC_HTOTAL;
    localparam int VTOTAL       = `ASIC_VTOTAL;
    localparam int FRAME_CLOCKS = HTOTAL * VTOTAL;
    localparam int HSYNC_START  = `ASIC_RBORDER + `ASIC_HFPORCH;
    localparam int HSYNC_END    = HSYNC_START + `ASIC_HSYNC;
    localparam int HBLANK_END   = HSYNC_END + `ASIC_HBPORCH;
    localparam int VSYNC_LINE   = `ASIC_VACTIVE + `ASIC_BBORDER + `ASIC_VFPORCH;
    localparam int VBLANK_START = `ASIC_VACTIVE + `ASIC_BBORDER;
    localparam int VBLANK_END   = VSYNC_LINE + `ASIC_VSYNC + `ASIC_VBPORCH;
    localparam int FETCH_START  = `ASIC_FETCH_HSTART;
    localparam logic [31:0] SEED = 32'h836b_0d76;

    logic                   clk;
    logic                   rst_n;
    asic_pkg::cpu_bus_t     bus;
    logic [7:0]             ram_data;
    logic [18:0]            vram_addr;
    logic [7:0]             data_to_cpu;
    logic                   data_enable_n;
    logic                   csync;
    logic                   int_n;
    asic_pkg::colour_t      pixel;

    // Raster position, register shadows and palette model
    int                     beam_hc;
    int                     beam_vc;
    logic [7:0]             vmpr_reg;
    logic [7:0]             border_reg;
    logic [31:0]            rng_state;
    asic_pkg::colour_t      clut_model [16];

    asic_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (bus),
        .ram_data      (ram_data),
        .vram_addr     (vram_addr),
        .data_to_cpu   (data_to_cpu),
        .data_enable_n (data_enable_n),
        .csync         (csync),
        .int_n         (int_n),
        .pixel         (pixel)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (!rst_n) begin
            beam_hc <= 0;
            beam_vc <= 0;
        end else if (beam_hc == HTOTAL - 1) begin
            beam_hc <= 0;
            beam_vc <= (beam_vc == VTOTAL - 1) ? 0 : beam_vc + 1;
        end else begin
            beam_hc <= beam_hc + 1;
        end
    end

    //////////////////////////////
    // Random source and VRAM model
    //////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(output logic [7:0] r);
        rng_state = lcg_next(rng_state);
        r = rng_state[23:16];
    endtask

    function automatic logic [7:0] ram_byte(input logic [18:0] a, input logic mode1);
        logic [31:0] h;
        h = lcg_next(lcg_next(SEED ^ 32'(a)));
        // Attribute bytes live where addr[12:11] is 3
        if (mode1 && a[12:11] == 2'b11)
            h[31] = 1'b0;
        return h[31:24];
    endfunction

    assign ram_data = ram_byte(vram_addr, vmpr_reg[6:5] != 2'd3);

    function automatic asic_pkg::colour_t default_entry(input logic [3:0] i);
        asic_pkg::colour_t c;
        c.g_hi   = i[2];
        c.r_hi   = i[1];
        c.b_hi   = i[0];
        c.g_lo   = i[2];
        c.r_lo   = i[1];
        c.b_lo   = i[0];
        c.bright = i[3] && (i != 4'd8);
        return c;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic [18:0] expected_addr(input int v, input int h);
        logic [8:0]  vb;
        logic [4:0]  col;
        logic [14:0] offs;
        vb   = 9'(v);
        col  = 5'((h - FETCH_START) / 16);
        offs = 15'(v * 128 + (h - FETCH_START) / 16 * 4 + (h % 16) / 2);
        if (vmpr_reg[6:5] == 2'd3)
            return {vmpr_reg[4:1], offs};
        else if (h % 16 < 4)
            return {vmpr_reg[4:0], 1'b0, vb[7:6], vb[2:0], vb[5:3], col};
        else
            return {vmpr_reg[4:0], 4'b0110, vb[7:3], col};
    endfunction

    function automatic asic_pkg::colour_t expected_pixel(input int v, input int h);
        int         d;
        int         k;
        int         ld;
        int         vl;
        logic       mode1;
        logic [7:0] b0;
        logic [7:0] b2;
        logic [3:0] idx;
        mode1 = (vmpr_reg[6:5] != 2'd3);
        if ((h >= `ASIC_RBORDER && h < HBLANK_END) ||
            (v >= VBLANK_START && v < VBLANK_END) || (border_reg[7] && !mode1))
            return '0;
        // Pixel k of the group loaded at clock ld
        d  = (h + HTOTAL - 10) % 16;
        k  = d / 2;
        ld = h - 1 - d;
        vl = v;
        if (ld < 0) begin
            ld = ld + HTOTAL;
            vl = (v == 0) ? VTOTAL - 1 : v - 1;
        end
        if (vl >= `ASIC_VACTIVE || ld < FETCH_START) begin
            idx = {border_reg[5], border_reg[2:0]};
        end else if (!mode1) begin
            b0  = ram_byte(expected_addr(vl, ld - 8 + 2 * (k / 2)), 1'b0);
            idx = (k % 2 == 1) ? b0[3:0] : b0[7:4];
        end else begin
            b0  = ram_byte(expected_addr(vl, ld - 8), 1'b1);
            b2  = ram_byte(expected_addr(vl, ld - 4), 1'b1);
            idx = b0[7 - k] ? {b2[6], b2[2:0]} : {b2[6], b2[5:3]};
        end
        return clut_model[idx];
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////
    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_failure(input string why);
        $display("%s at vc %0d hc %0d", why, beam_vc, beam_hc);
        abort_run();
    endtask

    task automatic check_colour(input string name, input asic_pkg::colour_t got,
                                input asic_pkg::colour_t exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h (vc %0d hc %0d)",
                     name, got, exp, beam_vc, beam_hc);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h (vc %0d hc %0d)",
                     name, got, exp, beam_vc, beam_hc);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [18:0] got, input logic [18:0] exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h (vc %0d hc %0d)",
                     name, got, exp, beam_vc, beam_hc);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h (vc %0d hc %0d)",
                     name, got, exp, beam_vc, beam_hc);
            abort_run();
        end
    endtask

    //////////////////////////////
    // Bus and raster helpers
    //////////////////////////////
    task automatic wait_beam(input int v, input int h);
        int n;
        n = 0;
        while (!(beam_vc == v && beam_hc == h)) begin
            if (n > FRAME_CLOCKS)
                report_failure("Timed out waiting for a raster position");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] hi, input logic [7:0] value);
        @(negedge clk);
        bus.iorq_n = 1'b0;
        bus.wr_n   = 1'b0;
        bus.addr   = {hi, port};
        bus.data   = value;
        @(negedge clk);
        bus.iorq_n = 1'b1;
        bus.wr_n   = 1'b1;
        if (port == `ASIC_PORT_VMPR)
            vmpr_reg = value;
        else if (port == `ASIC_PORT_BORDER)
            border_reg = value;
        else if (port == `ASIC_PORT_CLUT)
            clut_model[hi[3:0]] = asic_pkg::colour_t'(value[6:0]);
    endtask

    // Value sampled one clock after the strobe while the bus is still held
    task automatic io_read(input logic [7:0] port, output logic [7:0] value,
                           output logic en_n, output int v, output int h);
        @(negedge clk);
        bus.iorq_n = 1'b0;
        bus.rd_n   = 1'b0;
        bus.addr   = {8'h00, port};
        @(negedge clk);
        value      = data_to_cpu;
        en_n       = data_enable_n;
        v          = beam_vc;
        h          = beam_hc;
        bus.iorq_n = 1'b1;
        bus.rd_n   = 1'b1;
    endtask

    task automatic check_frame();
        int n;
        wait_beam(0, 0);
        for (n = 0; n < `ASIC_VACTIVE * HTOTAL; n++) begin
            if (beam_hc >= FETCH_START && beam_hc % 16 < 8 && beam_hc % 2 == 1)
                check_addr("vram_addr", vram_addr, expected_addr(beam_vc, beam_hc));
            if (beam_hc >= 272 && beam_hc <= 751)
                check_colour("pixel", pixel, expected_pixel(beam_vc, beam_hc));
            @(negedge clk);
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin
        logic [7:0] r;
        logic [7:0] val;
        logic [7:0] page;
        logic       en_n;
        int         v;
        int         h;
        int         n;
        clk        = 1'b0;
        rst_n      = 1'b0;
        bus.iorq_n = 1'b1;
        bus.rd_n   = 1'b1;
        bus.wr_n   = 1'b1;
        bus.addr   = 16'h0000;
        bus.data   = 8'h00;
        vmpr_reg   = 8'h00;
        border_reg = 8'h00;
        rng_state  = SEED;
        for (int i = 0; i < 16; i++)
            clut_model[i] = default_entry(4'(i));
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("int_n", int_n, 1'b1);
        check_bit("data_enable_n", data_enable_n, 1'b1);

        // Frame interrupt timing and line sync on line 1
        n = 0;
        while (int_n !== 1'b0 && n <= VSYNC_LINE * HTOTAL) begin
            if (beam_vc == 1)
                check_bit("csync", csync, !(beam_hc >= HSYNC_START && beam_hc < HSYNC_END));
            @(negedge clk);
            n++;
        end
        if (n != VSYNC_LINE * HTOTAL)
            report_failure("int_n did not fall at the start of vertical sync");

        for (int i = 0; i < 8; i++) begin
            next_rand(r);
            io_write(`ASIC_PORT_VMPR, 8'h00, r);
            io_read(`ASIC_PORT_VMPR, val, en_n, v, h);
            check_byte("data_to_cpu", val, r);
            check_bit("data_enable_n", en_n, 1'b0);
        end

        // Line interrupt on line 10 seen through the status port
        io_write(`ASIC_PORT_LINEINT, 8'h00, 8'd10);
        wait_beam(9, 0);
        n = 0;
        while (beam_vc != 12 && n < 4 * HTOTAL) begin
            io_read(`ASIC_PORT_STATUS, val, en_n, v, h);
            check_byte("status", val, {4'hf, !(v == VSYNC_LINE && h < FETCH_START), 2'b11,
                                       !(v == 10 && h < FETCH_START)});
            check_bit("data_enable_n", en_n, 1'b0);
            n++;
        end
        if (beam_vc != 12)
            report_failure("Timed out reading the status port");

        // Every other port reads as FF
        for (int p = 0; p < 256; p++) begin
            if (p != `ASIC_PORT_VMPR && p != `ASIC_PORT_STATUS) begin
                io_read(8'(p), val, en_n, v, h);
                check_byte("data_to_cpu", val, 8'hff);
                check_bit("data_enable_n", en_n, 1'b1);
            end
        end

        // Reset palette seen through the border colour
        for (int i = 0; i < 16; i++) begin
            wait_beam(200, 208 + 32 * i);
            io_write(`ASIC_PORT_BORDER, 8'h00, {2'b00, i[3], 2'b00, i[2:0]});
            wait_beam(200, 236 + 32 * i);
            check_colour("pixel", pixel, expected_pixel(beam_vc, beam_hc));
        end

        // Random palette and border colour
        for (int i = 0; i < 16; i++) begin
            next_rand(r);
            io_write(`ASIC_PORT_CLUT, 8'(i), r);
        end
        next_rand(r);
        io_write(`ASIC_PORT_BORDER, 8'h00, r & 8'h7f);
        wait_beam(200, 300);
        check_colour("pixel", pixel, clut_model[{border_reg[5], border_reg[2:0]}]);

        // Screen off in mode 4 blanks every pixel
        next_rand(page);
        io_write(`ASIC_PORT_VMPR, 8'h00, {3'b011, page[4:0]});
        io_write(`ASIC_PORT_BORDER, 8'h00, border_reg | 8'h80);
        wait_beam(210, 0);
        repeat (HTOTAL) begin
            check_colour("pixel", pixel, '0);
            @(negedge clk);
        end
        io_write(`ASIC_PORT_BORDER, 8'h00, border_reg & 8'h7f);
        check_frame();

        next_rand(page);
        io_write(`ASIC_PORT_VMPR, 8'h00, {3'b000, page[4:0]});
        check_frame();

        if (dut_i.assertions_i.error_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Concurrent assertions reported %0d failures",
                     dut_i.assertions_i.error_count);
            abort_run();
        end
    end

endmodule
